//--- Makefile
VERILATOR ?= verilator
TOP       ?= trap_unit_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
source/trap_pkg.sv
source/skid_buf.sv
source/exc_prio.sv
source/irq_select.sv
source/trap_csr.sv
source/trap_ctrl.sv
source/trap_unit.sv
verification/trap_unit_assert.sv
verification/trap_unit_tb.sv

//--- source/exc_prio.sv
`timescale 1ns/1ps

module exc_prio
  import trap_pkg::*;
(
  input  retire_item_t       item_i,
  output logic               exc_o,
  output logic [cause_w-1:0] exc_cause_o
);

  ////////////////////////////////////////
  // Fault priority
  ////////////////////////////////////////

  // Any fault flag turns the item into an exception
  assign exc_o = item_i.mpu_err | item_i.bus_err | item_i.illegal |
                 item_i.ecall | item_i.ebrk;

  // Fetch side faults come first since the instruction word itself is bad,
  // then decode faults, then the intentional environment calls
  always_comb begin
    exc_cause_o = '0;
    if (item_i.mpu_err) begin
      exc_cause_o = exc_instr_fault;
    end else if (item_i.bus_err) begin
      exc_cause_o = exc_instr_bus_fault;
    end else if (item_i.illegal) begin
      exc_cause_o = exc_illegal;
    end else if (item_i.ecall) begin
      exc_cause_o = exc_ecall_m;
    end else if (item_i.ebrk) begin
      exc_cause_o = exc_breakpoint;
    end
  end

endmodule

//--- source/irq_select.sv
`timescale 1ns/1ps

module irq_select
  import trap_pkg::*;
(
  input  logic [num_irq-1:0] irq_i,
  input  logic [num_irq-1:0] mie_i,
  input  logic               mstatus_mie_i,
  output logic               irq_o,
  output logic [cause_w-1:0] irq_id_o
);

  logic [num_irq-1:0] irq_masked;

  // A line counts only when its own enable and the global enable are set
  assign irq_masked = irq_i & mie_i & {num_irq{mstatus_mie_i}};

  assign irq_o = |irq_masked;

  ////////////////////////////////////////
  // Lowest line wins
  ////////////////////////////////////////

  // Scan from the top so the last hit is the lowest-numbered line
  always_comb begin
    irq_id_o = '0;
    for (int i = num_irq - 1; i >= 0; i--) begin
      if (irq_masked[i]) begin
        irq_id_o = cause_w'(i);
      end
    end
  end

endmodule

//--- source/skid_buf.sv
`timescale 1ns/1ps

module skid_buf #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // Two storage slots used as a small ring
  payload_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  // Ready comes from the fill count only, so it never sees out_ready_i
  assign in_ready_o  = (count_q != 2'd2);
  assign out_valid_o = (count_q != 2'd0);
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  // Oldest entry is always presented and stays put until popped
  assign out_data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      // A simultaneous push and pop leaves the count unchanged
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

//--- source/trap_csr.sv
`timescale 1ns/1ps

module trap_csr
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_ni,

  // Software access port
  input  logic               csr_we_i,
  input  logic [11:0]        csr_addr_i,
  input  logic [xlen-1:0]    csr_wdata_i,
  output logic [xlen-1:0]    csr_rdata_o,

  // Hardware updates from the trap controller
  input  logic               trap_take_i,
  input  logic               irq_take_i,
  input  logic               mret_take_i,
  input  logic [xlen-1:0]    trap_pc_i,
  input  logic [cause_w-1:0] exc_cause_i,
  input  logic [cause_w-1:0] irq_id_i,

  // Current state for the rest of the unit
  output logic [xlen-1:0]    mtvec_o,
  output logic [xlen-1:0]    mepc_o,
  output logic [num_irq-1:0] mie_o,
  output logic               mstatus_mie_o
);

  // Only MIE and MPIE of mstatus are implemented
  logic               mstatus_mie_q;
  logic               mstatus_mpie_q;
  logic [num_irq-1:0] mie_q;
  logic [xlen-1:0]    mtvec_q;
  logic [xlen-1:0]    mepc_q;
  logic [xlen-1:0]    mcause_q;
  logic               any_trap;
  logic [xlen-1:0]    trap_cause;

  assign any_trap = trap_take_i | irq_take_i;

  // Interrupts carry the line number with the MSB set
  assign trap_cause = irq_take_i ?
                      {1'b1, {(xlen-1-cause_w){1'b0}}, irq_id_i} :
                      {{(xlen-cause_w){1'b0}}, exc_cause_i};

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      csr_mstatus: begin
        csr_rdata_o[mstatus_mie_bit]  = mstatus_mie_q;
        csr_rdata_o[mstatus_mpie_bit] = mstatus_mpie_q;
      end
      csr_mie:    csr_rdata_o = {{(xlen-num_irq){1'b0}}, mie_q};
      csr_mtvec:  csr_rdata_o = mtvec_q;
      csr_mepc:   csr_rdata_o = mepc_q;
      csr_mcause: csr_rdata_o = mcause_q;
      // Unimplemented addresses read as zero
      default:    csr_rdata_o = '0;
    endcase
  end

  ////////////////////////////////////////
  // Register update
  ////////////////////////////////////////

  // The software write is applied first, and a trap or mret in the same
  // cycle then overwrites whatever fields it touches
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
      mie_q          <= '0;
      mtvec_q        <= mtvec_reset;
      mepc_q         <= '0;
      mcause_q       <= '0;
    end else begin
      if (csr_we_i) begin
        case (csr_addr_i)
          csr_mstatus: begin
            mstatus_mie_q  <= csr_wdata_i[mstatus_mie_bit];
            mstatus_mpie_q <= csr_wdata_i[mstatus_mpie_bit];
          end
          csr_mie:    mie_q    <= csr_wdata_i[num_irq-1:0];
          csr_mtvec:  mtvec_q  <= csr_wdata_i;
          csr_mepc:   mepc_q   <= {csr_wdata_i[xlen-1:1], 1'b0};
          csr_mcause: mcause_q <= csr_wdata_i;
          default:    ;
        endcase
      end
      if (any_trap) begin
        // Save the interrupted context and close the global enable
        mstatus_mpie_q <= mstatus_mie_q;
        mstatus_mie_q  <= 1'b0;
        mepc_q         <= {trap_pc_i[xlen-1:1], 1'b0};
        mcause_q       <= trap_cause;
      end else if (mret_take_i) begin
        mstatus_mie_q  <= mstatus_mpie_q;
        mstatus_mpie_q <= 1'b1;
      end
    end
  end

  assign mtvec_o       = mtvec_q;
  assign mepc_o        = mepc_q;
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

endmodule

//--- source/trap_ctrl.sv
`timescale 1ns/1ps

module trap_ctrl
  import trap_pkg::*;
(
  input  logic            clk,
  input  logic            rst_ni,

  // Head of the retire buffer
  input  logic            head_valid_i,
  input  retire_item_t    head_item_i,
  output logic            head_ready_o,

  // Decoded trap sources
  input  logic            exc_i,
  input  logic            irq_i,

  // CSR state needed for redirect targets
  input  logic [xlen-1:0] mepc_i,
  input  logic [xlen-1:0] mtvec_i,

  // Space in the redirect buffer
  input  logic            out_ready_i,

  // CSR update strobes
  output logic            trap_take_o,
  output logic            irq_take_o,
  output logic            mret_take_o,

  // Commit report
  output logic            commit_valid_o,
  output logic [xlen-1:0] commit_pc_o,

  // Push into the redirect buffer
  output logic            redir_valid_o,
  output redirect_t       redir_data_o
);

  logic decide;
  logic commit_take;

  ////////////////////////////////////////
  // Decision
  ////////////////////////////////////////

  // Nothing moves unless a redirect could be accepted, even for a plain commit
  assign decide = head_valid_i & out_ready_i;

  // Every decision consumes the head
  assign head_ready_o = decide;

  // Interrupt beats exception, exception beats mret, the rest commits
  assign irq_take_o  = decide & irq_i;
  assign trap_take_o = decide & ~irq_i & exc_i;
  assign mret_take_o = decide & ~irq_i & ~exc_i & head_item_i.mret;
  assign commit_take = decide & ~irq_i & ~exc_i & ~head_item_i.mret;

  // Traps go to the vector base with the mode bits cleared
  assign redir_valid_o = irq_take_o | trap_take_o | mret_take_o;

  always_comb begin
    redir_data_o = '0;
    if (mret_take_o) begin
      redir_data_o.pc = mepc_i;
    end else begin
      redir_data_o.pc = {mtvec_i[xlen-1:2], 2'b00};
    end
  end

  ////////////////////////////////////////
  // Commit pulse
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= commit_take;
    end
  end

  // The PC only matters while the pulse is high
  always_ff @(posedge clk) begin
    if (commit_take) begin
      commit_pc_o <= head_item_i.pc;
    end
  end

endmodule

//--- source/trap_pkg.sv
package trap_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data and PC width of the core
  localparam int unsigned xlen = 32;

  // Number of external interrupt lines, mapped onto mie bits 0 and up
  localparam int unsigned num_irq = 16;

  // Width of the cause field in mcause and of an interrupt line number
  localparam int unsigned cause_w = 5;

  ////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mie     = 12'h304;
  localparam logic [11:0] csr_mtvec   = 12'h305;
  localparam logic [11:0] csr_mepc    = 12'h341;
  localparam logic [11:0] csr_mcause  = 12'h342;

  // Trap vector base after reset
  localparam logic [xlen-1:0] mtvec_reset = 32'h100;

  ////////////////////////////////////////
  // Cause codes
  ////////////////////////////////////////

  // Instruction access fault, raised by the protection unit
  localparam logic [cause_w-1:0] exc_instr_fault     = 5'd1;
  localparam logic [cause_w-1:0] exc_illegal         = 5'd2;
  localparam logic [cause_w-1:0] exc_breakpoint      = 5'd3;
  localparam logic [cause_w-1:0] exc_ecall_m         = 5'd11;
  // Custom code for an instruction bus error
  localparam logic [cause_w-1:0] exc_instr_bus_fault = 5'd24;

  // mcause MSB that marks an interrupt
  localparam int unsigned mcause_irq_bit = xlen - 1;

  // Bit positions inside mstatus
  localparam int unsigned mstatus_mie_bit  = 3;
  localparam int unsigned mstatus_mpie_bit = 7;

  ////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////

  // One retired instruction with its already decoded fault flags
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic            illegal;
    logic            ecall;
    logic            ebrk;
    logic            bus_err;
    logic            mpu_err;
    logic            mret;
  } retire_item_t;

  // Fetch redirect sent back to the front end
  typedef struct packed {
    logic [xlen-1:0] pc;
  } redirect_t;

endpackage

//--- source/trap_unit.sv
`timescale 1ns/1ps

module trap_unit
  import trap_pkg::*;
(
  input  logic               clk,
  input  logic               rst_ni,

  // Retire stream
  input  logic               retire_valid_i,
  output logic               retire_ready_o,
  input  logic [xlen-1:0]    retire_pc_i,
  input  logic               retire_illegal_i,
  input  logic               retire_ecall_i,
  input  logic               retire_ebrk_i,
  input  logic               retire_bus_err_i,
  input  logic               retire_mpu_err_i,
  input  logic               retire_mret_i,

  // Redirect to fetch
  output logic               redirect_valid_o,
  input  logic               redirect_ready_i,
  output logic [xlen-1:0]    redirect_pc_o,

  // Commit report
  output logic               commit_valid_o,
  output logic [xlen-1:0]    commit_pc_o,

  // CSR port
  input  logic               csr_we_i,
  input  logic [11:0]        csr_addr_i,
  input  logic [xlen-1:0]    csr_wdata_i,
  output logic [xlen-1:0]    csr_rdata_o,

  // Level-sensitive interrupt lines
  input  logic [num_irq-1:0] irq_i
);

  retire_item_t       retire_item;
  retire_item_t       head_item;
  logic               head_valid;
  logic               head_ready;
  redirect_t          redir_in;
  redirect_t          redir_out;
  logic               redir_push;
  logic               redir_space;
  logic               exc;
  logic [cause_w-1:0] exc_cause;
  logic               irq;
  logic [cause_w-1:0] irq_id;
  logic               trap_take;
  logic               irq_take;
  logic               mret_take;
  logic [xlen-1:0]    mtvec;
  logic [xlen-1:0]    mepc;
  logic [num_irq-1:0] mie;
  logic               mstatus_mie;

  // Gather the loose retire fields into one stored item
  assign retire_item.pc      = retire_pc_i;
  assign retire_item.illegal = retire_illegal_i;
  assign retire_item.ecall   = retire_ecall_i;
  assign retire_item.ebrk    = retire_ebrk_i;
  assign retire_item.bus_err = retire_bus_err_i;
  assign retire_item.mpu_err = retire_mpu_err_i;
  assign retire_item.mret    = retire_mret_i;

  assign redirect_pc_o = redir_out.pc;

  skid_buf #(
    .payload_t (retire_item_t)
  ) u_retire_buf (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .in_valid_i  (retire_valid_i),
    .in_ready_o  (retire_ready_o),
    .in_data_i   (retire_item),
    .out_valid_o (head_valid),
    .out_ready_i (head_ready),
    .out_data_o  (head_item)
  );

  exc_prio u_exc_prio (
    .item_i      (head_item),
    .exc_o       (exc),
    .exc_cause_o (exc_cause)
  );

  irq_select u_irq_select (
    .irq_i         (irq_i),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .irq_o         (irq),
    .irq_id_o      (irq_id)
  );

  trap_csr u_trap_csr (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .csr_rdata_o   (csr_rdata_o),
    .trap_take_i   (trap_take),
    .irq_take_i    (irq_take),
    .mret_take_i   (mret_take),
    .trap_pc_i     (head_item.pc),
    .exc_cause_i   (exc_cause),
    .irq_id_i      (irq_id),
    .mtvec_o       (mtvec),
    .mepc_o        (mepc),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie)
  );

  trap_ctrl u_trap_ctrl (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .head_valid_i   (head_valid),
    .head_item_i    (head_item),
    .head_ready_o   (head_ready),
    .exc_i          (exc),
    .irq_i          (irq),
    .mepc_i         (mepc),
    .mtvec_i        (mtvec),
    .out_ready_i    (redir_space),
    .trap_take_o    (trap_take),
    .irq_take_o     (irq_take),
    .mret_take_o    (mret_take),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .redir_valid_o  (redir_push),
    .redir_data_o   (redir_in)
  );

  skid_buf #(
    .payload_t (redirect_t)
  ) u_redir_buf (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .in_valid_i  (redir_push),
    .in_ready_o  (redir_space),
    .in_data_i   (redir_in),
    .out_valid_o (redirect_valid_o),
    .out_ready_i (redirect_ready_i),
    .out_data_o  (redir_out)
  );

endmodule

//--- verification/trap_unit_assert.sv
`timescale 1ns/1ps

module trap_unit_assert
  import trap_pkg::*;
(
  input logic               clk,
  input logic               rst_ni,
  input logic               irq_take_i,
  input logic               trap_take_i,
  input logic [cause_w-1:0] irq_id_i,
  input retire_item_t       head_item_i,
  input logic [num_irq-1:0] irq_i,
  input logic [num_irq-1:0] mie_i,
  input logic               mstatus_mie_i,
  input logic [xlen-1:0]    mcause_i,
  input logic               redirect_valid_i,
  input logic               redirect_ready_i,
  input logic [xlen-1:0]    redirect_pc_i
);

  logic [num_irq-1:0] pending;
  logic [cause_w-1:0] exp_line;
  logic [cause_w-1:0] exp_code;

  // Lines that may interrupt right now
  assign pending = irq_i & mie_i & {num_irq{mstatus_mie_i}};

  // The lowest pending line is the one that should be taken
  always_comb begin
    logic found;
    exp_line = '0;
    found    = 1'b0;
    for (int i = 0; i < num_irq; i++) begin
      if (pending[i] && !found) begin
        exp_line = cause_w'(i);
        found    = 1'b1;
      end
    end
  end

  // Fault code of the head item, protection unit first and ebreak last
  always_comb begin
    exp_code = '0;
    if (head_item_i.mpu_err) begin
      exp_code = exc_instr_fault;
    end else if (head_item_i.bus_err) begin
      exp_code = exc_instr_bus_fault;
    end else if (head_item_i.illegal) begin
      exp_code = exc_illegal;
    end else if (head_item_i.ecall) begin
      exp_code = exc_ecall_m;
    end else if (head_item_i.ebrk) begin
      exp_code = exc_breakpoint;
    end
  end

  ////////////////////////////////////////
  // Trap entry
  ////////////////////////////////////////

  // A taken line must be pending, enabled in mie and globally enabled
  irq_enabled_a: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_take_i |-> mstatus_mie_i && irq_i[irq_id_i[3:0]] && mie_i[irq_id_i[3:0]])
    else $error("Interrupt line %0d taken while masked", irq_id_i);

  // mcause holds the lowest enabled line with the interrupt bit, MIE is closed
  irq_cause_a: assert property (@(posedge clk) disable iff (!rst_ni)
    irq_take_i |=> (mcause_i == {1'b1, {(xlen-1-cause_w){1'b0}}, $past(exp_line)}) &&
                   !mstatus_mie_i)
    else $error("Wrong mcause or MIE after an interrupt");

  // Exceptions leave the highest-priority fault code in mcause with bit 31 clear
  exc_cause_a: assert property (@(posedge clk) disable iff (!rst_ni)
    trap_take_i |=> (mcause_i == {{(xlen-cause_w){1'b0}}, $past(exp_code)}) &&
                    !mstatus_mie_i)
    else $error("Wrong mcause or MIE after an exception");

  ////////////////////////////////////////
  // Redirect output
  ////////////////////////////////////////

  redirect_hold_a: assert property (@(posedge clk) disable iff (!rst_ni)
    redirect_valid_i && !redirect_ready_i |=> redirect_valid_i && $stable(redirect_pc_i))
    else $error("Redirect dropped or changed while stalled");

endmodule

bind trap_unit trap_unit_assert u_trap_unit_assert (
  .clk              (clk),
  .rst_ni           (rst_ni),
  .irq_take_i       (irq_take),
  .trap_take_i      (trap_take),
  .irq_id_i         (irq_id),
  .head_item_i      (head_item),
  .irq_i            (irq_i),
  .mie_i            (mie),
  .mstatus_mie_i    (mstatus_mie),
  .mcause_i         (u_trap_csr.mcause_q),
  .redirect_valid_i (redirect_valid_o),
  .redirect_ready_i (redirect_ready_i),
  .redirect_pc_i    (redirect_pc_o)
);

//--- verification/trap_unit_tb.sv
`timescale 1ns/1ps

module trap_unit_tb
  import trap_pkg::*;
();

  // Longest wait in cycles before a handshake is declared dead
  localparam int unsigned timeout_cycles = 200;

  logic               clk;
  logic               rst_ni;
  logic               retire_valid_i;
  logic               retire_ready_o;
  logic [xlen-1:0]    retire_pc_i;
  logic               retire_illegal_i;
  logic               retire_ecall_i;
  logic               retire_ebrk_i;
  logic               retire_bus_err_i;
  logic               retire_mpu_err_i;
  logic               retire_mret_i;
  logic               redirect_valid_o;
  logic               redirect_ready_i;
  logic [xlen-1:0]    redirect_pc_o;
  logic               commit_valid_o;
  logic [xlen-1:0]    commit_pc_o;
  logic               csr_we_i;
  logic [11:0]        csr_addr_i;
  logic [xlen-1:0]    csr_wdata_i;
  logic [xlen-1:0]    csr_rdata_o;
  logic [num_irq-1:0] irq_i;

  integer             seed;
  logic               stall;
  logic [xlen-1:0]    next_pc;
  logic [xlen-1:0]    exp_commit_q [$];
  logic [xlen-1:0]    exp_redir_q [$];

  // Shadow copy of the machine CSRs, advanced in retire order
  logic               sh_mstatus_mie;
  logic               sh_mstatus_mpie;
  logic [num_irq-1:0] sh_mie;
  logic [xlen-1:0]    sh_mtvec;
  logic [xlen-1:0]    sh_mepc;
  logic [xlen-1:0]    sh_mcause;

  trap_unit u_trap_unit (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_val(input string field, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp) else begin
      fail_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                         $time, field, got, exp));
    end
  endtask

  // Step to just after the next rising edge, where all inputs change
  task automatic tick();
    @(posedge clk);
    #2;
    if (stall) begin
      redirect_ready_i = 1'b0;
    end else begin
      redirect_ready_i = ({$random(seed)} % 4) != 0;
    end
  endtask

  // Every commit and every redirect must match the head of its queue
  task automatic monitor_outputs();
    forever begin
      @(negedge clk);
      if (rst_ni && commit_valid_o) begin
        if (exp_commit_q.size() == 0) begin
          fail_run("A commit appeared with no instruction left to commit");
        end else begin
          check_val("commit_pc_o", commit_pc_o, exp_commit_q.pop_front());
        end
      end
      if (rst_ni && redirect_valid_o && redirect_ready_i) begin
        if (exp_redir_q.size() == 0) begin
          fail_run("A redirect was accepted with no trap or mret behind it");
        end else begin
          check_val("redirect_pc_o", redirect_pc_o, exp_redir_q.pop_front());
        end
      end
    end
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  task automatic take_trap(input logic [xlen-1:0] pc, input logic [xlen-1:0] cause);
    sh_mstatus_mpie = sh_mstatus_mie;
    sh_mstatus_mie  = 1'b0;
    sh_mepc         = pc & ~32'h1;
    sh_mcause       = cause;
    exp_redir_q.push_back(sh_mtvec & ~32'h3);
  endtask

  // Decision rule applied to one item in the order it reaches the head
  task automatic predict(input retire_item_t it);
    logic [num_irq-1:0] pend;
    int                 line;
    pend = irq_i & sh_mie & {num_irq{sh_mstatus_mie}};
    line = 0;
    for (int i = num_irq - 1; i >= 0; i--) begin
      if (pend[i]) line = i;
    end
    if (pend != '0) begin
      take_trap(it.pc, {1'b1, 26'b0, 5'(line)});
    end else if (it.mpu_err) begin
      take_trap(it.pc, 32'd1);
    end else if (it.bus_err) begin
      take_trap(it.pc, 32'd24);
    end else if (it.illegal) begin
      take_trap(it.pc, 32'd2);
    end else if (it.ecall) begin
      take_trap(it.pc, 32'd11);
    end else if (it.ebrk) begin
      take_trap(it.pc, 32'd3);
    end else if (it.mret) begin
      sh_mstatus_mie  = sh_mstatus_mpie;
      sh_mstatus_mpie = 1'b1;
      exp_redir_q.push_back(sh_mepc);
    end else begin
      exp_commit_q.push_back(it.pc);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Flags are {illegal, ecall, ebrk, bus_err, mpu_err, mret}
  task automatic send_item(input logic [5:0] flags);
    retire_item_t it;
    int           waited;
    it = {next_pc, flags};
    next_pc = next_pc + 32'd4;
    predict(it);
    retire_valid_i   = 1'b1;
    retire_pc_i      = it.pc;
    retire_illegal_i = it.illegal;
    retire_ecall_i   = it.ecall;
    retire_ebrk_i    = it.ebrk;
    retire_bus_err_i = it.bus_err;
    retire_mpu_err_i = it.mpu_err;
    retire_mret_i    = it.mret;
    waited = 0;
    while (!retire_ready_o) begin
      tick();
      waited++;
      if (waited > timeout_cycles) fail_run("Timeout: the retire input never accepted an item");
    end
    tick();
    retire_valid_i = 1'b0;
  endtask

  task automatic run_batch(input int n);
    logic [31:0] r;
    logic [5:0]  flags;
    for (int i = 0; i < n; i++) begin
      r = $random(seed);
      flags = 6'b0;
      // Roughly a third of the items carry faults, a few carry mret
      if (r[3:0] < 4'd5) flags[5:1] = r[8:4];
      if (r[3:0] == 4'd5) flags[0] = 1'b1;
      send_item(flags);
      if (r[10:9] == 2'd0) begin
        repeat (r[12:11]) tick();
      end
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (exp_commit_q.size() != 0 || exp_redir_q.size() != 0) begin
      tick();
      waited++;
      if (waited > timeout_cycles) fail_run("Timeout: expected commits or redirects never came out");
    end
  endtask

  // Writes are only issued while no item is in flight
  task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_addr_i  = addr;
    csr_wdata_i = data;
    case (addr)
      csr_mstatus: begin
        sh_mstatus_mie  = data[3];
        sh_mstatus_mpie = data[7];
      end
      csr_mie:    sh_mie    = data[15:0];
      csr_mtvec:  sh_mtvec  = data;
      csr_mepc:   sh_mepc   = data & ~32'h1;
      csr_mcause: sh_mcause = data;
      default:    ;
    endcase
    tick();
    csr_we_i = 1'b0;
  endtask

  // One read per cycle, so the address always moves just after an edge
  task automatic csr_check(input logic [11:0] addr, input logic [31:0] exp, input string name);
    csr_addr_i = addr;
    #5;
    check_val(name, csr_rdata_o, exp);
    tick();
  endtask

  task automatic check_all_csrs();
    csr_check(csr_mstatus, {24'b0, sh_mstatus_mpie, 3'b0, sh_mstatus_mie, 3'b0}, "mstatus");
    csr_check(csr_mie, {16'b0, sh_mie}, "mie");
    csr_check(csr_mtvec, sh_mtvec, "mtvec");
    csr_check(csr_mepc, sh_mepc, "mepc");
    csr_check(csr_mcause, sh_mcause, "mcause");
  endtask

  initial begin
    logic [31:0] r;
    seed = 27498;
    stall = 1'b0;
    next_pc = 32'h0000_1000;
    {retire_valid_i, retire_illegal_i, retire_ecall_i, retire_ebrk_i} = '0;
    {retire_bus_err_i, retire_mpu_err_i, retire_mret_i} = '0;
    retire_pc_i = '0;
    redirect_ready_i = 1'b1;
    csr_we_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    irq_i = '0;
    {sh_mstatus_mie, sh_mstatus_mpie, sh_mie, sh_mepc, sh_mcause} = '0;
    sh_mtvec = 32'h100;
    rst_ni = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    rst_ni = 1'b1;
    fork
      monitor_outputs();
    join_none
    check_val("retire_ready_o", {31'b0, retire_ready_o}, 32'd1);
    check_val("redirect_valid_o", {31'b0, redirect_valid_o}, 32'd0);
    check_all_csrs();

    // Software access, including an unimplemented address
    csr_write(csr_mtvec, 32'h0000_2203);
    csr_write(csr_mepc, 32'h0000_0457);
    csr_write(csr_mcause, 32'h8000_0005);
    csr_write(csr_mie, 32'h0000_a5c3);
    csr_write(csr_mstatus, 32'h0000_0080);
    csr_write(12'h7c0, 32'hdead_beef);
    check_all_csrs();
    csr_check(12'h7c0, 32'h0, "unknown csr");

    // Each fault alone with mepc and mcause read back, then random mixes
    for (int i = 1; i < 6; i++) begin
      send_item(6'(1 << i));
      wait_idle();
      check_all_csrs();
    end
    run_batch(40);
    wait_idle();
    check_all_csrs();

    // mret with MPIE set turns MIE on and returns to mepc
    csr_write(csr_mstatus, 32'h0000_0080);
    send_item(6'b000001);
    send_item(6'b010000);
    send_item(6'b000001);
    wait_idle();
    check_all_csrs();

    // Interrupt phases with random enables and pending lines
    for (int p = 0; p < 8; p++) begin
      r = $random(seed);
      csr_write(csr_mie, {16'b0, r[15:0]});
      csr_write(csr_mstatus, {24'b0, r[16], 3'b0, r[17] | p[0], 3'b0});
      irq_i = r[31:16] | 16'h0100;
      run_batch(12);
      wait_idle();
      check_all_csrs();
    end
    irq_i = '0;

    // Hold off the redirect consumer until the retire input backs up
    // Traps and mrets alternate so each queued redirect has its own target
    stall = 1'b1;
    redirect_ready_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      send_item(6'b000100);
      send_item(6'b000001);
    end
    begin
      int waited;
      waited = 0;
      while (retire_ready_o) begin
        tick();
        waited++;
        if (waited > timeout_cycles) fail_run("Timeout: retire_ready_o never fell under a stall");
      end
    end
    repeat (5) tick();
    stall = 1'b0;
    wait_idle();
    check_all_csrs();

    $display("Simulation PASSED");
    $finish;
  end

endmodule
